// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_adc_deser
FILE_LIST = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: adc_deser_top.sv
`timescale 1ns/10ps
module adc_deser_top import adc_pkg::*; #(
	parameter int LOCK_WORDS   = 4,
	parameter int SETTLE_WORDS = 2,
	parameter int MAX_SLIPS    = 12 // keep <= 15, 4 bit count
) (
	input  logic     adc_bit_clk,
	input  logic     rst,
	// serial link, one pair per lane per clock
	input  pair_t    lane_in [NUM_LANES],
	input  pair_t    frame_in,
	// wishbone
	input  logic     wb_cyc,
	input  logic     wb_stb,
	input  logic     wb_we,
	input  wb_addr_t wb_adr,
	input  wb_data_t wb_dat_i,
	output wb_data_t wb_dat_o,
	output logic     wb_ack,
	// parallel sample stream
	output sample_t  sample_data [NUM_LANES],
	output logic     sample_valid, // one cycle per word
	output logic     locked
);

	logic      word_strobe; // last pair of word this cycle
	logic      slip;
	sample_t   frame_word;  // captured frame lane
	logic      fail;
	slip_cnt_t slip_count;
	logic      auto_align;
	logic      manual_slip;
	logic      restart;

	frame_counter u_frame_counter (
		.adc_bit_clk (adc_bit_clk),
		.rst         (rst),
		.slip        (slip),
		.word_strobe (word_strobe),
		.word_valid  (sample_valid), // same pulse marks new samples
		.phase       ()
	);

	// data lanes 0..7, then the frame lane on the last pass
	for (genvar i = 0; i <= NUM_LANES; i++) begin : g_lane
		if (i < NUM_LANES) begin : g_data
			lane_deserializer u_lane (
				.adc_bit_clk (adc_bit_clk),
				.rst         (rst),
				.pair_in     (lane_in[i]),
				.word_strobe (word_strobe),
				.word        (sample_data[i])
			);
		end else begin : g_frame
			lane_deserializer u_lane (
				.adc_bit_clk (adc_bit_clk),
				.rst         (rst),
				.pair_in     (frame_in),
				.word_strobe (word_strobe),
				.word        (frame_word)
			);
		end
	end

	align_fsm #(
		.LOCK_WORDS   (LOCK_WORDS),
		.SETTLE_WORDS (SETTLE_WORDS),
		.MAX_SLIPS    (MAX_SLIPS)
	) u_align_fsm (
		.adc_bit_clk (adc_bit_clk),
		.rst         (rst),
		.frame_word  (frame_word),
		.word_valid  (sample_valid),
		.auto_align  (auto_align),
		.manual_slip (manual_slip),
		.restart     (restart),
		.slip        (slip),
		.locked      (locked),
		.fail        (fail),
		.slip_count  (slip_count)
	);

	wb_ctrl_regs u_wb_ctrl_regs (
		.adc_bit_clk (adc_bit_clk),
		.rst         (rst),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_i    (wb_dat_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack      (wb_ack),
		.locked      (locked),
		.fail        (fail),
		.slip_count  (slip_count),
		.frame_word  (frame_word),
		.sample_data (sample_data),
		.auto_align  (auto_align),
		.manual_slip (manual_slip),
		.restart     (restart)
	);

endmodule

// File: adc_pkg.sv
package adc_pkg;

	localparam int SAMPLE_BITS    = 12; // adc resolution
	localparam int PAIRS_PER_WORD = 6;  // p/n pairs per sample
	localparam int NUM_LANES      = 8;  // data lanes, frame lane extra

	typedef logic [SAMPLE_BITS-1:0] sample_t; // one adc word
	typedef logic [1:0]             pair_t;   // [1] = p (rise), [0] = n (fall)
	typedef logic [2:0]             phase_t;  // pair position in word
	typedef logic [3:0]             slip_cnt_t;

	// frame lane sends six ones then six zeros, msb first
	localparam sample_t FRAME_PATTERN = 12'b1111_1100_0000;

	typedef logic [31:0] wb_data_t;
	typedef logic [3:0]  wb_addr_t; // word address

	localparam wb_addr_t REG_CTRL        = 4'd0;
	localparam wb_addr_t REG_STATUS      = 4'd1;
	localparam wb_addr_t REG_FRAME       = 4'd2;
	localparam wb_addr_t REG_SAMPLE_BASE = 4'd4; // lane n at 4+n

	// ctrl fields
	localparam int CTRL_AUTO_BIT    = 0; // auto align enable, r/w
	localparam int CTRL_SLIP_BIT    = 1; // manual slip pulse, reads 0
	localparam int CTRL_RESTART_BIT = 2; // restart pulse, reads 0

	// status fields
	localparam int STAT_LOCKED_BIT = 0;
	localparam int STAT_FAIL_BIT   = 1;
	localparam int STAT_SLIP_LSB   = 8; // slip count in 11:8

	typedef enum logic [2:0] {
		ALIGN_IDLE,   // auto align off, manual slips only
		ALIGN_SEARCH, // compare frame words
		ALIGN_SLIP,   // one cycle slip pulse
		ALIGN_SETTLE, // let the new boundary flush through
		ALIGN_LOCKED,
		ALIGN_FAIL
	} align_state_t;

endpackage

// File: align_fsm.sv
`timescale 1ns/10ps
module align_fsm import adc_pkg::*; #(
	parameter int LOCK_WORDS   = 4,  // matches in a row for lock
	parameter int SETTLE_WORDS = 2,  // words ignored after a slip
	parameter int MAX_SLIPS    = 12  // at most 15
) (
	input  logic      adc_bit_clk,
	input  logic      rst,
	input  sample_t   frame_word,
	input  logic      word_valid,
	input  logic      auto_align,
	input  logic      manual_slip,
	input  logic      restart,
	output logic      slip,
	output logic      locked,
	output logic      fail,
	output slip_cnt_t slip_count
);

	localparam int MATCH_W  = $clog2(LOCK_WORDS + 1);
	localparam int SETTLE_W = $clog2(SETTLE_WORDS + 1);

	align_state_t        state;
	logic [MATCH_W-1:0]  match_cnt;  // consecutive pattern hits
	logic [SETTLE_W-1:0] settle_cnt; // words seen since slip
	logic                frame_ok;

	assign frame_ok = (frame_word == FRAME_PATTERN);

	always_ff @(posedge adc_bit_clk) begin
		if (rst) begin
			state      <= ALIGN_IDLE;
			match_cnt  <= '0;
			settle_cnt <= '0;
			slip_count <= '0;
		end else if (!auto_align) begin
			state      <= ALIGN_IDLE; // manual mode
			match_cnt  <= '0;
			settle_cnt <= '0;
			slip_count <= '0;
		end else if (restart) begin
			state      <= ALIGN_SEARCH; // start over, clears fail
			match_cnt  <= '0;
			settle_cnt <= '0;
			slip_count <= '0;
		end else begin
			case (state)
				ALIGN_IDLE: begin
					state <= ALIGN_SEARCH; // auto align just enabled
				end
				ALIGN_SEARCH: begin
					if (word_valid) begin
						if (frame_ok) begin
							if (match_cnt == MATCH_W'(LOCK_WORDS - 1)) begin
								state     <= ALIGN_LOCKED;
								match_cnt <= '0;
							end else begin
								match_cnt <= match_cnt + 1'b1;
							end
						end else begin
							match_cnt <= '0; // run broken
							if (slip_count == slip_cnt_t'(MAX_SLIPS)) begin
								state <= ALIGN_FAIL; // all slips used up
							end else begin
								state <= ALIGN_SLIP;
							end
						end
					end
				end
				ALIGN_SLIP: begin
					slip_count <= slip_count + 1'b1;
					settle_cnt <= '0;
					state      <= ALIGN_SETTLE;
				end
				ALIGN_SETTLE: begin
					// first words after a slip can be half old, half new
					if (word_valid) begin
						if (settle_cnt == SETTLE_W'(SETTLE_WORDS - 1)) begin
							state <= ALIGN_SEARCH;
						end else begin
							settle_cnt <= settle_cnt + 1'b1;
						end
					end
				end
				ALIGN_LOCKED: begin
					if (word_valid && !frame_ok) begin
						state <= ALIGN_SEARCH; // lost frame, search again
					end
				end
				ALIGN_FAIL: begin
					state <= ALIGN_FAIL; // wait for restart
				end
				default: begin
					state <= ALIGN_IDLE;
				end
			endcase
		end
	end

	// idle passes manual slip straight to the counter
	assign slip   = (state == ALIGN_IDLE) ? manual_slip : (state == ALIGN_SLIP);
	assign locked = (state == ALIGN_LOCKED);
	assign fail   = (state == ALIGN_FAIL);

endmodule

// File: frame_counter.sv
`timescale 1ns/10ps
module frame_counter import adc_pkg::*; (
	input  logic   adc_bit_clk,
	input  logic   rst,
	input  logic   slip,        // hold phase one cycle
	output logic   word_strobe, // last pair of word on input
	output logic   word_valid,  // new word in lane registers
	output phase_t phase
);

	localparam phase_t LAST_PHASE = phase_t'(PAIRS_PER_WORD - 1);

	// comb so the lanes latch in the same cycle as the last pair
	assign word_strobe = (phase == LAST_PHASE);

	always_ff @(posedge adc_bit_clk) begin
		if (rst) begin
			phase      <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= word_strobe; // lines up with latched word
			if (!slip) begin
				if (word_strobe) begin
					phase <= '0; // wrap at word end
				end else begin
					phase <= phase + 1'b1;
				end
			end
			// on slip the phase is held, so the
			// boundary lands one pair later
		end
	end

endmodule

// File: lane_deserializer.sv
`timescale 1ns/10ps
module lane_deserializer import adc_pkg::*; (
	input  logic    adc_bit_clk,
	input  logic    rst,
	input  pair_t   pair_in,     // p bit high, msb first
	input  logic    word_strobe, // pair_in is last of word
	output sample_t word
);

	localparam int HIST_BITS = SAMPLE_BITS - $bits(pair_t); // five earlier pairs

	logic [HIST_BITS-1:0] history;

	always_ff @(posedge adc_bit_clk) begin
		if (rst) begin
			history <= '0;
			word    <= '0;
		end else begin
			// oldest pair drifts toward the top
			history <= {history[HIST_BITS-$bits(pair_t)-1:0], pair_in};
			if (word_strobe) begin
				word <= {history, pair_in}; // earliest pair in 11:10
			end
		end
	end

endmodule

// File: project.f
adc_pkg.sv
frame_counter.sv
lane_deserializer.sv
align_fsm.sv
wb_ctrl_regs.sv
adc_deser_top.sv
tb_adc_deser.sv

// File: tb_adc_deser.sv
`timescale 1ns/10ps
module tb_adc_deser import adc_pkg::*; ();

	localparam int LOCK_WORDS      = 4;
	localparam int SETTLE_WORDS    = 2;
	localparam int MAX_SLIPS       = 12;
	localparam int RESET_CYCLES    = 16;
	localparam int LOCK_LIMIT      = 200; // cycles from enable to lock
	localparam int FAIL_LIMIT      = 600; // cycles to run out of slips
	localparam int STREAM_WORDS    = 16;  // words per stream check
	localparam int ACK_LIMIT       = 16;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + LOCK_LIMIT + FAIL_LIMIT +
		2 * STREAM_WORDS * PAIRS_PER_WORD + 600; // register and slip tests in the margin

	typedef sample_t [NUM_LANES-1:0] word_set_t; // one word per lane

	logic      adc_bit_clk;
	logic      rst;
	pair_t     lane_in [NUM_LANES] = '{default: '0};
	pair_t     frame_in = '0;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	wb_addr_t  wb_adr;
	wb_data_t  wb_dat_i;
	wb_data_t  wb_dat_o;
	logic      wb_ack;
	sample_t   sample_data [NUM_LANES];
	logic      sample_valid;
	logic      locked;

	logic [31:0] lfsr_state = 32'h41f6ad50;
	int          n_errors = 0;
	int          words_checked = 0;
	int          cycle_cnt = 0;
	int          start_pos = 0;  // pair offset k of the stream
	int          pos = 0;        // next pair of cur_set to send
	bit          ser_on = 0;
	bit          ser_run = 0;
	bit          frame_zero = 0; // frame lane stuck low
	bit          check_req = 0;
	bit          check_stream = 0;
	word_set_t   cur_set = '0;
	word_set_t   last_sent = '0; // last word set fully sent
	word_set_t   exp_set;
	word_set_t   tx_q [$];
	word_set_t   sent_q [$];    // sent but not yet seen on sample_data

	adc_deser_top #(
		.LOCK_WORDS   (LOCK_WORDS),
		.SETTLE_WORDS (SETTLE_WORDS),
		.MAX_SLIPS    (MAX_SLIPS)
	) dut (
		.adc_bit_clk  (adc_bit_clk),
		.rst          (rst),
		.lane_in      (lane_in),
		.frame_in     (frame_in),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_i     (wb_dat_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack       (wb_ack),
		.sample_data  (sample_data),
		.sample_valid (sample_valid),
		.locked       (locked)
	);

	initial begin
		adc_bit_clk = 1'b0;
		forever #4 adc_bit_clk = ~adc_bit_clk; // 8 ns period
	end

	always @(posedge adc_bit_clk) cycle_cnt <= cycle_cnt + 1;

	// galois lfsr with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] draw_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int b = 0; b < n; b++) begin
			val = {val[30:0], lfsr_state[0]}; // lsb is the output bit
			lfsr_state = (lfsr_state >> 1) ^
				(lfsr_state[0] ? 32'h8020_0003 : 32'h0);
		end
		return val;
	endfunction

	function automatic word_set_t random_word_set();
		word_set_t ws;
		for (int i = 0; i < NUM_LANES; i++) begin
			ws[i] = sample_t'(draw_bits(SAMPLE_BITS));
		end
		return ws;
	endfunction

	task automatic report_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		n_errors++;
		$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
	endtask

	// serializer model and stream checker share one negedge process
	always @(negedge adc_bit_clk) begin
		if (check_stream && sample_valid) begin // pulse belongs to last completed word
			if (sent_q.size() == 0) begin
				n_errors++;
				$display("sample_valid at %0t with no word sent since checking began",
					$time);
			end else begin
				exp_set = sent_q.pop_front();
				for (int i = 0; i < NUM_LANES; i++) begin
					if (sample_data[i] !== exp_set[i]) begin
						report_value($sformatf("sample_data lane %0d", i),
							sample_data[i], exp_set[i]);
					end
				end
				words_checked++;
			end
		end
		if (!check_req) begin
			check_stream = 0;
		end else if (!check_stream && pos == 0) begin
			check_stream = 1; // start on a word boundary
			sent_q.delete();
		end
		if (ser_on) begin
			if (!ser_run) begin
				start_pos = int'(draw_bits(5)) % PAIRS_PER_WORD; // k for this run
				pos = start_pos;
				ser_run = 1;
			end
			if (pos == 0) begin
				if (tx_q.size() == 0) begin
					tx_q.push_back(random_word_set());
				end
				cur_set = tx_q.pop_front();
			end
			for (int i = 0; i < NUM_LANES; i++) begin
				lane_in[i] <= cur_set[i][SAMPLE_BITS-1-2*pos -: 2]; // msb pair first
			end
			frame_in <= frame_zero ? 2'b00 : FRAME_PATTERN[SAMPLE_BITS-1-2*pos -: 2];
			if (pos == PAIRS_PER_WORD - 1) begin
				last_sent = cur_set;
				if (check_stream) begin
					sent_q.push_back(cur_set);
				end
				pos = 0;
			end else begin
				pos++;
			end
		end
	end

	// waits for ack and checks that it drops after one cycle while stb stays high
	task automatic finish_cycle(input wb_addr_t adr, output wb_data_t dat);
		int n;
		n = 0;
		do begin
			@(negedge adc_bit_clk);
			n++;
		end while (!wb_ack && n < ACK_LIMIT);
		if (!wb_ack) begin
			n_errors++;
			$display("Wishbone access to address %0d got no acknowledge by %0t", adr, $time);
		end
		dat = wb_dat_o;
		@(negedge adc_bit_clk);
		if (wb_ack) begin
			n_errors++;
			$display("wb_ack for address %0d stayed high past one cycle at %0t", adr, $time);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
		@(negedge adc_bit_clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		finish_cycle(adr, dat);
	endtask

	task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
		wb_data_t unused;
		@(negedge adc_bit_clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_i = dat;
		finish_cycle(adr, unused);
	endtask

	// returns on the negedge that shows a sample_valid pulse
	task automatic wait_word();
		int n;
		n = 0;
		do begin
			@(negedge adc_bit_clk);
			n++;
		end while (!sample_valid && n < 4 * PAIRS_PER_WORD);
		if (!sample_valid) begin
			n_errors++;
			$display("no sample_valid pulse within %0d cycles at %0t", n, $time);
		end
	endtask

	task automatic verify_reset_state();
		wb_data_t rd;
		rst = 1'b1;
		repeat (RESET_CYCLES - 1) @(negedge adc_bit_clk);
		if (locked !== 1'b0) report_value("locked in reset", locked, 0);
		if (sample_valid !== 1'b0) report_value("sample_valid in reset", sample_valid, 0);
		@(posedge adc_bit_clk);
		ser_on = 1; // first pair lands on the first cycle out of reset
		@(negedge adc_bit_clk);
		rst = 1'b0;
		wb_read(REG_STATUS, rd);
		if (rd !== '0) report_value("STATUS after reset", rd, 0);
		wb_read(REG_CTRL, rd);
		if (rd !== '0) report_value("CTRL after reset", rd, 0);
		wb_read(wb_addr_t'(3), rd); // hole in the map
		if (rd !== '0) report_value("unmapped address 3", rd, 0);
	endtask

	task automatic align_from_offset();
		wb_data_t rd;
		int start;
		int exp_slips;
		exp_slips = (PAIRS_PER_WORD - start_pos) % PAIRS_PER_WORD; // each slip adds one pair
		wb_write(REG_CTRL, 32'h1);
		start = cycle_cnt;
		while (!locked && cycle_cnt - start < LOCK_LIMIT) @(negedge adc_bit_clk);
		if (!locked) begin
			n_errors++;
			$display("no lock within %0d cycles for offset %0d", LOCK_LIMIT, start_pos);
		end
		wb_read(REG_STATUS, rd);
		if (rd[STAT_LOCKED_BIT] !== 1'b1) report_value("STATUS locked", rd, 1);
		if (rd[STAT_FAIL_BIT] !== 1'b0) report_value("STATUS fail", rd, 0);
		if (rd[STAT_SLIP_LSB +: $bits(slip_cnt_t)] !== slip_cnt_t'(exp_slips)) begin
			report_value("STATUS slip count", rd[STAT_SLIP_LSB +: $bits(slip_cnt_t)],
				exp_slips);
		end
	endtask

	task automatic check_stream_words(input string label);
		int base;
		int start;
		@(posedge adc_bit_clk);
		base = words_checked;
		check_req = 1;
		start = cycle_cnt;
		while (words_checked - base < STREAM_WORDS &&
			cycle_cnt - start < (STREAM_WORDS + 2) * PAIRS_PER_WORD) begin
			@(posedge adc_bit_clk);
		end
		if (words_checked - base < STREAM_WORDS) begin
			n_errors++;
			$display("only %0d of %0d sample words seen %s", words_checked - base,
				STREAM_WORDS, label);
		end
		@(posedge adc_bit_clk);
		check_req = 0;
	endtask

	task automatic compare_registers();
		wb_data_t rd;
		sample_t  exp;
		wb_read(REG_FRAME, rd);
		if (rd !== wb_data_t'(FRAME_PATTERN)) report_value("FRAME", rd, FRAME_PATTERN);
		for (int i = 0; i < NUM_LANES; i++) begin
			wait_word(); // read lands well before the next latch
			exp = last_sent[i];
			wb_read(wb_addr_t'(REG_SAMPLE_BASE + i), rd);
			if (rd !== wb_data_t'(exp)) report_value($sformatf("SAMPLE lane %0d", i), rd, exp);
		end
	endtask

	task automatic walk_manual_slips();
		wb_data_t rd;
		sample_t  exp;
		wb_write(REG_CTRL, 32'h0); // auto align off so the link stays aligned
		wb_write(REG_CTRL, 32'h2);
		repeat (3) wait_word();
		// boundary one pair later makes the word start at the second pair
		exp = {FRAME_PATTERN[SAMPLE_BITS-3:0], FRAME_PATTERN[SAMPLE_BITS-1 -: 2]};
		wb_read(REG_FRAME, rd);
		if (rd !== wb_data_t'(exp)) report_value("FRAME after one slip", rd, exp);
		repeat (PAIRS_PER_WORD - 1) wb_write(REG_CTRL, 32'h2);
		repeat (3) wait_word();
		wb_read(REG_FRAME, rd);
		if (rd !== wb_data_t'(FRAME_PATTERN)) begin
			report_value("FRAME after six slips", rd, FRAME_PATTERN);
		end
		check_stream_words("after six manual slips");
	endtask

	task automatic run_out_of_slips();
		wb_data_t rd;
		int start;
		@(posedge adc_bit_clk);
		frame_zero = 1;
		wb_write(REG_CTRL, 32'h1);
		start = cycle_cnt;
		rd = '0;
		while (!rd[STAT_FAIL_BIT] && cycle_cnt - start < FAIL_LIMIT) begin
			wb_read(REG_STATUS, rd);
		end
		if (!rd[STAT_FAIL_BIT]) begin
			n_errors++;
			$display("fail never set within %0d cycles with the frame lane low", FAIL_LIMIT);
		end else if (rd[STAT_SLIP_LSB +: $bits(slip_cnt_t)] !== slip_cnt_t'(MAX_SLIPS)) begin
			report_value("slip count at fail", rd[STAT_SLIP_LSB +: $bits(slip_cnt_t)],
				MAX_SLIPS);
		end
		wb_write(REG_CTRL, 32'h5); // restart with auto align kept on
		wb_read(REG_STATUS, rd);
		if (rd[STAT_FAIL_BIT] !== 1'b0) report_value("fail after restart", rd, 0);
		if (rd[STAT_SLIP_LSB +: $bits(slip_cnt_t)] !== '0) begin
			report_value("slip count after restart", rd[STAT_SLIP_LSB +: $bits(slip_cnt_t)], 0);
		end
	endtask

	initial begin
		rst      = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_i = '0;
		verify_reset_state();
		align_from_offset();
		check_stream_words("after lock");
		compare_registers();
		walk_manual_slips();
		run_out_of_slips();
		$display("errors: %0d, stream words checked: %0d", n_errors, words_checked);
		if (n_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge adc_bit_clk);
		$display("run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
		$display("Errors found");
		$finish;
	end

endmodule

// File: wb_ctrl_regs.sv
`timescale 1ns/10ps
module wb_ctrl_regs import adc_pkg::*; (
	input  logic      adc_bit_clk,
	input  logic      rst,
	// wishbone classic slave
	input  logic      wb_cyc,
	input  logic      wb_stb,
	input  logic      wb_we,
	input  wb_addr_t  wb_adr,
	input  wb_data_t  wb_dat_i,
	output wb_data_t  wb_dat_o,
	output logic      wb_ack,
	// alignment status
	input  logic      locked,
	input  logic      fail,
	input  slip_cnt_t slip_count,
	// captured words
	input  sample_t   frame_word,
	input  sample_t   sample_data [NUM_LANES],
	// control to align fsm
	output logic      auto_align,
	output logic      manual_slip, // one cycle pulse
	output logic      restart      // one cycle pulse
);

	localparam int LANE_W = $clog2(NUM_LANES);

	logic              access;     // new cycle, ack not yet given
	logic              sample_hit; // address in sample window
	logic [LANE_W-1:0] lane_sel;
	wb_data_t          rd_data;

	// ~wb_ack makes ack a single cycle even if stb stays high
	assign access = wb_cyc && wb_stb && !wb_ack;

	assign sample_hit = (wb_adr >= REG_SAMPLE_BASE) &&
		(wb_adr < REG_SAMPLE_BASE + NUM_LANES);
	assign lane_sel = LANE_W'(wb_adr - REG_SAMPLE_BASE);

	// read mux, unmapped reads as zero
	always_comb begin
		rd_data = '0;
		if (sample_hit) begin
			rd_data = wb_data_t'(sample_data[lane_sel]); // zero ext
		end else begin
			case (wb_adr)
				REG_CTRL: begin
					rd_data[CTRL_AUTO_BIT] = auto_align; // pulse bits read 0
				end
				REG_STATUS: begin
					rd_data[STAT_LOCKED_BIT] = locked;
					rd_data[STAT_FAIL_BIT]   = fail;
					rd_data[STAT_SLIP_LSB +: $bits(slip_cnt_t)] = slip_count;
				end
				REG_FRAME: begin
					rd_data = wb_data_t'(frame_word);
				end
				default: begin
					rd_data = '0;
				end
			endcase
		end
	end

	always_ff @(posedge adc_bit_clk) begin
		if (rst) begin
			wb_ack      <= 1'b0;
			auto_align  <= 1'b0;
			manual_slip <= 1'b0;
			restart     <= 1'b0;
		end else begin
			wb_ack      <= access;
			manual_slip <= 1'b0; // pulses clear by default
			restart     <= 1'b0;
			// write lands on the edge that raises ack
			if (access && wb_we && (wb_adr == REG_CTRL)) begin
				auto_align  <= wb_dat_i[CTRL_AUTO_BIT];
				manual_slip <= wb_dat_i[CTRL_SLIP_BIT];
				restart     <= wb_dat_i[CTRL_RESTART_BIT];
			end
			// other addresses are read only, writes dropped
		end
	end

	// read data valid alongside ack
	always_ff @(posedge adc_bit_clk) begin
		if (access && !wb_we) begin
			wb_dat_o <= rd_data;
		end
	end

endmodule
